// ==== sim/ecc_patterns.txt ====
# op addr wdata exp_rdata exp_resp, all hex
# W checks bresp only, R checks rdata and rresp
W 000 deadbeef 00000000 0
W 004 12345678 00000000 0
W 008 a5a5a5a5 00000000 0
W 03c 0f0f0f0f 00000000 0
R 000 00000000 deadbeef 0
R 004 00000000 12345678 0
R 008 00000000 a5a5a5a5 0
R 03c 00000000 0f0f0f0f 0
# single data bit flip, corrected on read
W 100 00000010 00000000 0
R 100 00000000 00000010 0
W 010 cafef00d 00000000 0
R 100 00000000 00000000 0
R 010 00000000 cafef00d 0
R 108 00000000 00000101 0
# single check bit flip, then a clean rewrite
W 104 00000001 00000000 0
W 014 55aa33cc 00000000 0
R 014 00000000 55aa33cc 0
R 108 00000000 00000201 0
W 014 76543210 00000000 0
R 014 00000000 76543210 0
R 108 00000000 00000201 0
# two data bits, raw data with SLVERR
W 100 00000003 00000000 0
W 018 600dcafe 00000000 0
R 018 00000000 600dcafd 2
R 108 00000000 00010203 0
# status clear and unmapped offset
W 108 00000000 00000000 0
R 108 00000000 00000000 0
R 200 00000000 00000000 2
W 200 12345678 00000000 2
R 000 00000000 deadbeef 0

// ==== compile.f ====
+incdir+sim
hdl/ecc_pkg.sv
hdl/ecc_ifs.sv
hdl/ecc_axi_front.sv
hdl/ecc_store.sv
hdl/ecc_correct.sv
hdl/ecc_ram_top.sv
sim/tb_ecc_ram.sv

// ==== Makefile ====
# Verilator build and run for the ECC scratch memory testbench

VERILATOR ?= verilator
TOP       ?= tb_ecc_ram
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j $(JOBS)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/tb_axi_tasks.svh ====
// ============================
// AXI4-Lite master tasks
// single writes and reads with random
// bready/rready delays from a Galois LFSR
// ============================
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

logic [31:0] lfsr_state = 32'h991b_b39c;

function automatic bit next_random_bit();
   bit out;
   out = lfsr_state[0];
   lfsr_state = lfsr_state >> 1;
   if (out)
      lfsr_state = lfsr_state ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
   return out;
endfunction

// 0 to 3 idle cycles before raising a ready
function automatic int pick_delay();
   int d;
   d = 0;
   d[0] = next_random_bit();
   d[1] = next_random_bit();
   return d;
endfunction

// one transaction in flight, so no address or data channel may be open
task automatic expect_readys_low();
   check_value("awready", 32'(awready), 32'd0);
   check_value("wready", 32'(wready), 32'd0);
   check_value("arready", 32'(arready), 32'd0);
endtask

task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                          output logic [1:0] resp);
   bit aw_done;
   bit w_done;
   bit aw_go;
   bit w_go;
   bit got;
   aw_done = 1'b0;
   w_done  = 1'b0;
   got     = 1'b0;
   @(posedge clk);
   awvalid <= 1'b1;
   awaddr  <= addr;
   wvalid  <= 1'b1;
   wdata   <= data;
   wstrb   <= 4'hf;
   while (!(aw_done && w_done)) begin
      @(negedge clk);                     // readys are settled mid-cycle
      aw_go = awvalid && awready;
      w_go  = wvalid && wready;
      @(posedge clk);
      if (aw_go) begin
         awvalid <= 1'b0;
         aw_done = 1'b1;
      end
      if (w_go) begin
         wvalid <= 1'b0;
         w_done = 1'b1;
      end
   end
   repeat (pick_delay()) @(posedge clk);
   bready <= 1'b1;
   while (!got) begin
      @(negedge clk);
      got  = bvalid;
      resp = bresp;
      expect_readys_low();
      check_value("rvalid", 32'(rvalid), 32'd0);   // no read answer during a write
      @(posedge clk);
   end
   bready <= 1'b0;
endtask

task automatic read_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                         output logic [1:0] resp);
   bit ar_go;
   bit got;
   ar_go = 1'b0;
   got   = 1'b0;
   @(posedge clk);
   arvalid <= 1'b1;
   araddr  <= addr;
   while (!ar_go) begin
      @(negedge clk);
      ar_go = arready;
      @(posedge clk);
   end
   arvalid <= 1'b0;
   repeat (pick_delay()) @(posedge clk);
   rready <= 1'b1;
   while (!got) begin
      @(negedge clk);
      got  = rvalid;
      data = rdata;
      resp = rresp;
      expect_readys_low();
      check_value("bvalid", 32'(bvalid), 32'd0);
      @(posedge clk);
   end
   rready <= 1'b0;
endtask

`endif

// ==== sim/tb_ecc_ram.sv ====
// ============================
// tb_ecc_ram
// testbench for the SECDED scratch memory, replays
// AXI4-Lite transactions from the pattern file
// ============================
`timescale 1ns/1ns

module tb_ecc_ram import ecc_pkg::*; ();

   localparam int    DEPTH        = 16;
   localparam string PATTERN_FILE = "sim/ecc_patterns.txt";

   logic              clk = 1'b0;
   logic              rst_l;
   logic              awvalid;
   logic              awready;
   logic [ADDR_W-1:0] awaddr;
   logic              wvalid;
   logic              wready;
   logic [DATA_W-1:0] wdata;
   logic [3:0]        wstrb;
   logic              bvalid;
   logic              bready;
   logic [1:0]        bresp;
   logic              arvalid;
   logic              arready;
   logic [ADDR_W-1:0] araddr;
   logic              rvalid;
   logic              rready;
   logic [DATA_W-1:0] rdata;
   logic [1:0]        rresp;

   // one entry per transaction line
   logic [7:0]        pat_op [$];
   logic [ADDR_W-1:0] pat_addr [$];
   logic [DATA_W-1:0] pat_wdata [$];
   logic [DATA_W-1:0] pat_rdata [$];
   logic [1:0]        pat_resp [$];
   bit                loaded = 1'b0;      // lets the watchdog size its limit

   always #5 clk = ~clk;

   ecc_ram_top #(.DEPTH(DEPTH)) dut_i (
      .clk     (clk),
      .rst_l   (rst_l),
      .awvalid (awvalid),
      .awready (awready),
      .awaddr  (awaddr),
      .wvalid  (wvalid),
      .wready  (wready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .bvalid  (bvalid),
      .bready  (bready),
      .bresp   (bresp),
      .arvalid (arvalid),
      .arready (arready),
      .araddr  (araddr),
      .rvalid  (rvalid),
      .rready  (rready),
      .rdata   (rdata),
      .rresp   (rresp)
   );

   task automatic abort_run();
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, actual, expected);
         abort_run();
      end
   endtask

   `include "tb_axi_tasks.svh"

   task automatic load_patterns();
      int                fd;
      string             line;
      logic [7:0]        op;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wd;
      logic [DATA_W-1:0] rd;
      logic [1:0]        resp;
      fd = $fopen(PATTERN_FILE, "r");
      if (fd == 0) begin
         $display("cannot open pattern file %s", PATTERN_FILE);
         abort_run();
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin   // skip comments and blanks
               if ($sscanf(line, "%c %h %h %h %h", op, addr, wd, rd, resp) != 5
                   || (op != "W" && op != "R")) begin
                  $display("malformed pattern line: %s", line);
                  abort_run();
               end else begin
                  pat_op.push_back(op);
                  pat_addr.push_back(addr);
                  pat_wdata.push_back(wd);
                  pat_rdata.push_back(rd);
                  pat_resp.push_back(resp);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic run_line(input int i);
      logic [DATA_W-1:0] data;
      logic [1:0]        resp;
      string             where;
      where = $sformatf("(entry %0d, addr 0x%03h)", i, pat_addr[i]);
      if (pat_op[i] == "W") begin
         write_word(pat_addr[i], pat_wdata[i], resp);
         check_value({"bresp ", where}, 32'(resp), 32'(pat_resp[i]));
      end else begin
         read_word(pat_addr[i], data, resp);
         check_value({"rdata ", where}, data, pat_rdata[i]);
         check_value({"rresp ", where}, 32'(resp), 32'(pat_resp[i]));
      end
   endtask

   // watchdog, limit scales with the number of transactions
   initial begin
      wait (loaded);
      repeat (pat_op.size() * 20 + 100) @(posedge clk);
      $display("watchdog timeout, run did not finish within %0d cycles",
               pat_op.size() * 20 + 100);
      abort_run();
   end

   initial begin
      rst_l   = 1'b0;
      awvalid = 1'b0;
      awaddr  = '0;
      wvalid  = 1'b0;
      wdata   = '0;
      wstrb   = 4'h0;
      bready  = 1'b0;
      arvalid = 1'b0;
      araddr  = '0;
      rready  = 1'b0;
      load_patterns();
      if (pat_op.size() == 0) begin
         $display("pattern file holds no transactions");
         abort_run();
      end
      loaded = 1'b1;
      repeat (4) @(posedge clk);
      rst_l <= 1'b1;
      @(posedge clk);
      for (int i = 0; i < pat_op.size(); i++)
         run_line(i);
      $display("PASS: all tests");
      $finish;
   end

endmodule

// ==== hdl/ecc_ram_top.sv ====
// ============================
// ecc_ram_top
// SECDED scratch memory behind an AXI4-Lite slave,
// front end, store and correct stages in a row
// ============================
`timescale 1ns/1ns

module ecc_ram_top import ecc_pkg::*; #(
   parameter int DEPTH = 16          // words, power of two, 2 to 64
) (
   input  logic              clk,
   input  logic              rst_l,
   input  logic              awvalid,
   output logic              awready,
   input  logic [ADDR_W-1:0] awaddr,
   input  logic              wvalid,
   output logic              wready,
   input  logic [DATA_W-1:0] wdata,
   input  logic [3:0]        wstrb,
   output logic              bvalid,
   input  logic              bready,
   output logic [1:0]        bresp,
   input  logic              arvalid,
   output logic              arready,
   input  logic [ADDR_W-1:0] araddr,
   output logic              rvalid,
   input  logic              rready,
   output logic [DATA_W-1:0] rdata,
   output logic [1:0]        rresp
);
   ecc_req_if #(.DEPTH(DEPTH)) req_if ();
   ecc_word_if                 word_if ();
   ecc_rsp_if                  rsp_if ();

   ecc_axi_front #(.DEPTH(DEPTH)) front_i (
      .clk     (clk),
      .rst_l   (rst_l),
      .awvalid (awvalid),
      .awready (awready),
      .awaddr  (awaddr),
      .wvalid  (wvalid),
      .wready  (wready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .bvalid  (bvalid),
      .bready  (bready),
      .bresp   (bresp),
      .arvalid (arvalid),
      .arready (arready),
      .araddr  (araddr),
      .rvalid  (rvalid),
      .rready  (rready),
      .rdata   (rdata),
      .rresp   (rresp),
      .req     (req_if),
      .rsp     (rsp_if)
   );

   ecc_store #(.DEPTH(DEPTH)) store_i (
      .clk   (clk),
      .rst_l (rst_l),
      .req   (req_if),
      .word  (word_if)
   );

   ecc_correct correct_i (
      .clk   (clk),
      .rst_l (rst_l),
      .word  (word_if),
      .rsp   (rsp_if)
   );

endmodule

// ==== hdl/ecc_correct.sv ====
// ============================
// ecc_correct
// result stage, syndrome check, single-bit fix,
// error grading and sticky status with counters
// ============================
`timescale 1ns/1ns

module ecc_correct import ecc_pkg::*; (
   input  logic          clk,
   input  logic          rst_l,
   ecc_word_if.target    word,
   ecc_rsp_if.initiator  rsp
);
   codeword_t         cw;
   logic [ECC_W-1:0]  syn;
   logic [ECC_W-1:0]  exp_ecc;
   logic              sgl_err;
   logic              dbl_err;
   logic [38:0]       ham;           // hamming position order, bit 0 is position 1
   logic [38:0]       err_mask;
   logic [38:0]       ham_fix;
   logic [DATA_W-1:0] data_fix;
   logic              mem_rd;
   logic              sgl_flag;
   logic              dbl_flag;
   logic [7:0]        sgl_cnt;
   logic [7:0]        dbl_cnt;
   logic [DATA_W-1:0] status_word;

   assign cw      = word.payload.cw;
   assign exp_ecc = ecc_gen(cw.data);
   assign syn[5:0] = exp_ecc[5:0] ^ cw.ecc[5:0];
   assign syn[6]   = (^cw.data) ^ (^cw.ecc);   // odd means one flipped bit

   assign sgl_err = (syn != '0) & syn[6];
   assign dbl_err = (syn != '0) & ~syn[6];

   assign ham = {cw.ecc[6], cw.data[31:26], cw.ecc[5], cw.data[25:11], cw.ecc[4],
                 cw.data[10:4], cw.ecc[3], cw.data[3:1], cw.ecc[2], cw.data[0],
                 cw.ecc[1:0]};

   always_comb begin
      for (int i = 1; i < 40; i++)
         err_mask[i-1] = (syn[5:0] == i[5:0]);
   end

   assign ham_fix  = sgl_err ? (ham ^ err_mask) : ham;
   assign data_fix = {ham_fix[37:32], ham_fix[30:16], ham_fix[14:8], ham_fix[6:4], ham_fix[2]};

   assign mem_rd      = word.valid & ~word.write & (word.kind == OP_MEM);
   assign status_word = {8'h00, dbl_cnt, sgl_cnt, 6'b0, dbl_flag, sgl_flag};

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         sgl_flag  <= 1'b0;
         dbl_flag  <= 1'b0;
         sgl_cnt   <= '0;
         dbl_cnt   <= '0;
         rsp.valid <= 1'b0;
      end else begin
         rsp.valid <= word.valid;
         if (word.valid & word.write & (word.kind == OP_STATUS)) begin
            sgl_flag <= 1'b0;                  // any write clears
            dbl_flag <= 1'b0;
            sgl_cnt  <= '0;
            dbl_cnt  <= '0;
         end else if (mem_rd) begin
            if (sgl_err) begin
               sgl_flag <= 1'b1;
               if (sgl_cnt != 8'hff) sgl_cnt <= sgl_cnt + 8'd1;
            end
            if (dbl_err) begin
               dbl_flag <= 1'b1;
               if (dbl_cnt != 8'hff) dbl_cnt <= dbl_cnt + 8'd1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (word.valid) begin
         rsp.write <= word.write;
         rsp.resp  <= OKAY;
         rsp.rdata <= '0;
         if (word.kind == OP_BAD)
            rsp.resp <= SLVERR;
         if (!word.write) begin
            case (word.kind)
               OP_MEM: begin
                  rsp.rdata <= data_fix;       // raw data on a double error
                  if (dbl_err) rsp.resp <= SLVERR;
               end
               OP_STATUS:   rsp.rdata <= status_word;
               OP_INJ_DATA,
               OP_INJ_ECC:  rsp.rdata <= word.payload.rg.value;
               default:     ;
            endcase
         end
      end
   end

endmodule

// ==== hdl/ecc_store.sv ====
// ============================
// ecc_store
// execute stage, codeword array and one-shot
// data and check-bit inject registers
// ============================
`timescale 1ns/1ns

module ecc_store import ecc_pkg::*; #(
   parameter int DEPTH = 16
) (
   input  logic           clk,
   input  logic           rst_l,
   ecc_req_if.target      req,
   ecc_word_if.initiator  word
);
   payload_u          mem [DEPTH];
   logic [DATA_W-1:0] inj_data;      // data bits to flip on next mem write
   logic [ECC_W-1:0]  inj_ecc;
   payload_u          wr_word;
   payload_u          rd_word;
   logic              mem_wr;

   assign mem_wr = req.valid & req.write & (req.kind == OP_MEM);

   // check bits come from the clean data, then both halves take the inject masks
   always_comb begin
      wr_word.cw.data = req.wdata ^ inj_data;
      wr_word.cw.ecc  = ecc_gen(req.wdata) ^ inj_ecc;
   end

   always_comb begin
      rd_word.rg.pad   = '0;
      rd_word.rg.value = '0;
      case (req.kind)
         OP_MEM:      rd_word = mem[req.index];
         OP_INJ_DATA: rd_word.rg.value = inj_data;
         OP_INJ_ECC:  rd_word.rg.value = {{(DATA_W-ECC_W){1'b0}}, inj_ecc};
         default:     ;                         // status and bad handled downstream
      endcase
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         inj_data   <= '0;
         inj_ecc    <= '0;
         word.valid <= 1'b0;
      end else begin
         word.valid <= req.valid;
         if (mem_wr) begin
            inj_data <= '0;                     // one shot
            inj_ecc  <= '0;
         end else if (req.valid & req.write) begin
            if (req.kind == OP_INJ_DATA) inj_data <= req.wdata;
            if (req.kind == OP_INJ_ECC)  inj_ecc  <= req.wdata[ECC_W-1:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (mem_wr)
         mem[req.index] <= wr_word;
      if (req.valid) begin
         word.write   <= req.write;
         word.kind    <= req.kind;
         word.payload <= rd_word;
      end
   end

endmodule

// ==== hdl/ecc_axi_front.sv ====
// ============================
// ecc_axi_front
// AXI4-Lite slave, one transaction at a time, decodes
// the address and holds the response until taken
// ============================
`timescale 1ns/1ns

module ecc_axi_front import ecc_pkg::*; #(
   parameter int DEPTH = 16
) (
   input  logic              clk,
   input  logic              rst_l,
   input  logic              awvalid,
   output logic              awready,
   input  logic [ADDR_W-1:0] awaddr,
   input  logic              wvalid,
   output logic              wready,
   input  logic [DATA_W-1:0] wdata,
   input  logic [3:0]        wstrb,
   output logic              bvalid,
   input  logic              bready,
   output logic [1:0]        bresp,
   input  logic              arvalid,
   output logic              arready,
   input  logic [ADDR_W-1:0] araddr,
   output logic              rvalid,
   input  logic              rready,
   output logic [DATA_W-1:0] rdata,
   output logic [1:0]        rresp,
   ecc_req_if.initiator      req,
   ecc_rsp_if.target         rsp
);
   localparam int IDX_W = $clog2(DEPTH);
   localparam logic [ADDR_W-1:0] MEM_LIMIT = ADDR_W'(DEPTH * 4);

   logic              busy;          // accepted, response not yet taken
   logic              aw_held;
   logic              w_held;
   logic [ADDR_W-1:0] aw_addr_q;
   logic [DATA_W-1:0] wdata_q;
   logic              aw_fire;
   logic              w_fire;
   logic              ar_fire;
   logic              wr_accept;
   logic              rsp_done;
   logic [ADDR_W-1:0] wr_addr;
   logic [DATA_W-1:0] wr_data;
   logic [ADDR_W-1:0] req_addr;

   function automatic op_kind_e decode_kind(input logic [ADDR_W-1:0] addr);
      op_kind_e k;
      if (addr[1:0] == 2'b00 && addr < MEM_LIMIT)
         k = OP_MEM;
      else if (addr == REG_INJ_DATA)
         k = OP_INJ_DATA;
      else if (addr == REG_INJ_ECC)
         k = OP_INJ_ECC;
      else if (addr == REG_STATUS)
         k = OP_STATUS;
      else
         k = OP_BAD;
      return k;
   endfunction

   assign awready = ~busy & ~aw_held;
   assign wready  = ~busy & ~w_held;
   assign arready = ~busy;

   assign aw_fire = awvalid & awready;
   assign w_fire  = wvalid & wready;
   assign ar_fire = arvalid & arready;

   assign wr_addr = aw_held ? aw_addr_q : awaddr;
   assign wr_data = w_held ? wdata_q : wdata;

   // read wins when both are ready in the same cycle
   assign wr_accept = ~busy & (aw_held | aw_fire) & (w_held | w_fire) & ~ar_fire;
   assign req_addr  = ar_fire ? araddr : wr_addr;
   assign rsp_done  = (bvalid & bready) | (rvalid & rready);

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         busy      <= 1'b0;
         aw_held   <= 1'b0;
         w_held    <= 1'b0;
         req.valid <= 1'b0;
         bvalid    <= 1'b0;
         rvalid    <= 1'b0;
      end else begin
         req.valid <= ar_fire | wr_accept;
         if (ar_fire | wr_accept)
            busy <= 1'b1;
         else if (rsp_done)
            busy <= 1'b0;

         if (wr_accept) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
         end else begin
            if (aw_fire) aw_held <= 1'b1;   // AW arrived ahead of W, or beside a read
            if (w_fire)  w_held  <= 1'b1;
         end

         if (rsp.valid & rsp.write)
            bvalid <= 1'b1;
         else if (bvalid & bready)
            bvalid <= 1'b0;

         if (rsp.valid & ~rsp.write)
            rvalid <= 1'b1;
         else if (rvalid & rready)
            rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (aw_fire) aw_addr_q <= awaddr;
      if (w_fire)  wdata_q   <= wdata;

      if (ar_fire | wr_accept) begin
         req.write <= ~ar_fire;
         req.kind  <= decode_kind(req_addr);
         req.index <= req_addr[IDX_W+1:2];   // word index
         req.wdata <= wr_data;
      end

      if (rsp.valid & rsp.write)
         bresp <= rsp.resp;
      if (rsp.valid & ~rsp.write) begin
         rresp <= rsp.resp;
         rdata <= rsp.rdata;
      end
   end

endmodule

// ==== hdl/ecc_ifs.sv ====
// ============================
// ecc interfaces
// request, stored word and response links between
// the front end, store and correct stages
// ============================
`timescale 1ns/1ns

interface ecc_req_if import ecc_pkg::*; #(
   parameter int DEPTH = 16
) ();
   localparam int IDX_W = $clog2(DEPTH);

   logic              valid;       // one-cycle pulse, no ready
   logic              write;
   op_kind_e          kind;
   logic [IDX_W-1:0]  index;
   logic [DATA_W-1:0] wdata;

   modport initiator (output valid, write, kind, index, wdata);
   modport target    (input  valid, write, kind, index, wdata);
endinterface

interface ecc_word_if import ecc_pkg::*; ();
   logic     valid;
   logic     write;
   op_kind_e kind;
   payload_u payload;

   modport initiator (output valid, write, kind, payload);
   modport target    (input  valid, write, kind, payload);
endinterface

interface ecc_rsp_if import ecc_pkg::*; ();
   logic              valid;
   logic              write;
   axi_resp_e         resp;
   logic [DATA_W-1:0] rdata;

   modport initiator (output valid, write, resp, rdata);
   modport target    (input  valid, write, resp, rdata);
endinterface

// ==== hdl/ecc_pkg.sv ====
// ============================
// ecc_pkg
// shared widths, register map, payload types and the
// SECDED check-bit generator for the scratch memory
// ============================
package ecc_pkg;

   localparam int DATA_W = 32;
   localparam int ECC_W  = 7;        // 6 hamming bits + overall parity
   localparam int ADDR_W = 12;

   localparam logic [ADDR_W-1:0] REG_INJ_DATA = 12'h100;
   localparam logic [ADDR_W-1:0] REG_INJ_ECC  = 12'h104;
   localparam logic [ADDR_W-1:0] REG_STATUS   = 12'h108;

   typedef enum logic [2:0] {
      OP_MEM,
      OP_INJ_DATA,
      OP_INJ_ECC,
      OP_STATUS,
      OP_BAD
   } op_kind_e;

   typedef enum logic [1:0] {
      OKAY   = 2'd0,
      SLVERR = 2'd2
   } axi_resp_e;

   typedef struct packed {
      logic [ECC_W-1:0]  ecc;
      logic [DATA_W-1:0] data;
   } codeword_t;

   typedef struct packed {
      logic [ECC_W-1:0]  pad;
      logic [DATA_W-1:0] value;
   } reg_view_t;

   // stage payload, a stored codeword or a plain register value
   typedef union packed {
      codeword_t cw;
      reg_view_t rg;
   } payload_u;

   function automatic logic [ECC_W-1:0] ecc_gen(input logic [DATA_W-1:0] d);
      logic [5:0] h;
      h[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13]
           ^ d[15] ^ d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^ d[28] ^ d[30];
      h[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13]
           ^ d[16] ^ d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^ d[28] ^ d[31];
      h[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14] ^ d[15]
           ^ d[16] ^ d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[29] ^ d[30] ^ d[31];
      h[3] = (^d[10:4]) ^ (^d[25:18]);
      h[4] = ^d[25:11];
      h[5] = ^d[31:26];
      // overall parity covers data and hamming bits
      return {(^d) ^ (^h), h};
   endfunction

endpackage
